//--- fas_add_round.sv
`include "fas_settings.svh"

// Stages 3 and 4, signed add then round
module fas_add_round (
	input  logic        clk,
	input  logic        rst,
	fas_stage_if.sink   aln,
	fas_stage_if.source sum
);

	localparam logic [`FAS_SIG_W-1:0] ROUND_INC = `FAS_SIG_W'(1) << `FAS_ROUND_BIT;

	logic                  valid_s3;
	logic                  sign_s3;
	logic [`FAS_SIG_W-1:0] sig_s3;
	logic [`FAS_EXP_W-1:0] exp_s3;
	logic [`FAS_SIG_W-1:0] sig_sum;
	logic [`FAS_SIG_W-1:0] sig_rnd;

	//////////////////////////////////////////////////
	// Stage 3, significand add
	//////////////////////////////////////////////////

	always_comb begin
		if (aln.payload.sm_sig == '0) begin
			// Nothing left of the smaller operand
			sig_sum = aln.payload.lg_sig;
		end else if (aln.payload.lg_sign == aln.payload.sm_sign) begin
			sig_sum = aln.payload.lg_sig + aln.payload.sm_sig;
		end else begin
			// Larger minus smaller, cannot go negative
			sig_sum = aln.payload.lg_sig - aln.payload.sm_sig;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_s3 <= 1'b0;
			sign_s3  <= 1'b0;
			sig_s3   <= '0;
			exp_s3   <= '0;
		end else begin
			valid_s3 <= aln.valid;
			if (aln.valid) begin
				// Result takes the larger operand's sign
				sign_s3 <= aln.payload.lg_sign;
				sig_s3  <= sig_sum;
				exp_s3  <= aln.payload.base_exp;
			end
		end
	end

	//////////////////////////////////////////////////
	// Stage 4, round half up on the guard bits
	//////////////////////////////////////////////////

	assign sig_rnd = sig_s3[`FAS_ROUND_BIT] ? sig_s3 + ROUND_INC : sig_s3;

	always_ff @(posedge clk) begin
		if (rst) begin
			sum.valid   <= 1'b0;
			sum.payload <= '0;
		end else begin
			sum.valid <= valid_s3;
			if (valid_s3) begin
				sum.payload.rnd.sign        <= sign_s3;
				sum.payload.rnd.exponent    <= exp_s3;
				sum.payload.rnd.significand <= sig_rnd;
			end
		end
	end

endmodule

//--- fas_align.sv
`include "fas_settings.svh"

// Stage 2, put both significands on the larger exponent
module fas_align (
	input  logic        clk,
	input  logic        rst,
	fas_stage_if.sink   ord,
	fas_stage_if.source aln
);

	localparam logic [`FAS_EXP_W-1:0] GUARD = `FAS_GUARD_SHIFT;
	// Largest difference that still leaves a bit of the smaller operand
	localparam logic [`FAS_EXP_W-1:0] REACH = `FAS_GUARD_SHIFT + `FAS_SIG_W - 1;
	localparam logic [`FAS_SHIFT_W-1:0] SH_FULL = `FAS_SIG_W;

	fas_pkg::fas_operand_t   larger;
	fas_pkg::fas_operand_t   smaller;
	logic [`FAS_EXP_W-1:0]   exp_diff;
	logic [`FAS_SIG_W-1:0]   lg_sig;
	logic                    sm_left;
	logic [`FAS_SHIFT_W-1:0] sm_shift_n;
	logic [`FAS_SIG_W-1:0]   sm_sig;

	assign larger  = ord.payload.larger;
	assign smaller = ord.payload.smaller;

	// Never negative, stage 1 sorted by magnitude
	assign exp_diff = larger.exponent - smaller.exponent;

	// Guard bits below the larger operand, plain wiring
	assign lg_sig = larger.significand << `FAS_GUARD_SHIFT;

	//////////////////////////////////////////////////
	// Smaller operand shift
	//////////////////////////////////////////////////

	always_comb begin
		if (exp_diff < GUARD) begin
			// Close exponents, still some guard room left
			sm_left    = 1'b1;
			sm_shift_n = `FAS_SHIFT_W'(GUARD - exp_diff);
		end else if (exp_diff <= REACH) begin
			sm_left    = 1'b0;
			sm_shift_n = `FAS_SHIFT_W'(exp_diff - GUARD);
		end else begin
			// Falls off the end entirely
			sm_left    = 1'b0;
			sm_shift_n = SH_FULL;
		end
	end

	fas_shift32 u_sm_shift (
		.shift_n    (sm_shift_n),
		.shift_left (sm_left),
		.v          (smaller.significand),
		.q          (sm_sig)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			aln.valid   <= 1'b0;
			aln.payload <= '0;
		end else begin
			aln.valid <= ord.valid;
			if (ord.valid) begin
				aln.payload.lg_sign  <= larger.sign;
				aln.payload.lg_sig   <= lg_sig;
				aln.payload.sm_sign  <= smaller.sign;
				aln.payload.sm_sig   <= sm_sig;
				// Guard bits move the binary point down
				aln.payload.base_exp <= larger.exponent - GUARD;
			end
		end
	end

	// Relies on the magnitude sort in stage 1
	a_exp_order: assert property (@(posedge clk) disable iff (rst)
		ord.valid |-> larger.exponent >= smaller.exponent)
		else $error("fas_align: larger exponent below smaller one");

endmodule

//--- fas_normalize.sv
`include "fas_settings.svh"

// Stage 5, bring the leading one back to the hidden bit
module fas_normalize (
	input  logic                  clk,
	input  logic                  rst,
	fas_stage_if.sink             sum,
	output logic                  out_valid,
	output logic                  res_sign,
	output logic [`FAS_EXP_W-1:0] res_exponent,
	output logic [`FAS_SIG_W-1:0] res_significand
);

	localparam int P_W = $clog2(`FAS_SIG_W);
	localparam logic [P_W-1:0] TARGET = `FAS_MAN_W;
	localparam logic [`FAS_SHIFT_W-1:0] SH_TINY = `FAS_SIG_W / 2;

	fas_pkg::fas_operand_t   in_op;
	fas_pkg::fas_operand_t   res;
	logic                    found;
	logic [P_W-1:0]          lead_pos;
	logic                    norm_left;
	logic [`FAS_SHIFT_W-1:0] norm_n;
	logic [`FAS_EXP_W-1:0]   exp_new;
	logic [`FAS_SIG_W-1:0]   sig_norm;
	logic                    flush;

	assign in_op = sum.payload.rnd;

	//////////////////////////////////////////////////
	// Leading one
	//////////////////////////////////////////////////

	// Upward scan, last hit is the highest bit
	always_comb begin
		found    = 1'b0;
		lead_pos = '0;
		for (int i = `FAS_NORM_MIN_BIT; i < `FAS_SIG_W; i++) begin
			if (in_op.significand[i]) begin
				found    = 1'b1;
				lead_pos = P_W'(i);
			end
		end
	end

	// Shift direction and exponent fix-up
	always_comb begin
		if (!found) begin
			// Only low bits left, fixed shift and zero exponent
			norm_left = 1'b1;
			norm_n    = SH_TINY;
			exp_new   = '0;
		end else if (lead_pos >= TARGET) begin
			norm_left = 1'b0;
			norm_n    = `FAS_SHIFT_W'(lead_pos - TARGET);
			exp_new   = in_op.exponent + `FAS_EXP_W'(lead_pos - TARGET);
		end else begin
			// Cancellation, pull the significand up
			norm_left = 1'b1;
			norm_n    = `FAS_SHIFT_W'(TARGET - lead_pos);
			exp_new   = in_op.exponent - `FAS_EXP_W'(TARGET - lead_pos);
		end
	end

	fas_shift32 u_norm_shift (
		.shift_n    (norm_n),
		.shift_left (norm_left),
		.v          (in_op.significand),
		.q          (sig_norm)
	);

	// Near-total cancellation counts as zero
	assign flush = in_op.significand < `FAS_SIG_W'(`FAS_FLUSH_LIMIT);

	//////////////////////////////////////////////////
	// Result register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			res       <= '0;
		end else begin
			out_valid <= sum.valid;
			if (sum.valid) begin
				if (flush) begin
					res <= '0;
				end else begin
					res.sign        <= in_op.sign;
					res.exponent    <= exp_new;
					res.significand <= sig_norm;
				end
			end
		end
	end

	assign res_sign        = res.sign;
	assign res_exponent    = res.exponent;
	assign res_significand = res.significand;

	// Guard bits and rounding upstream leave no small odd remainders,
	// so even the fixed 16-bit shift path lands on the hidden bit
	a_hidden_bit: assert property (@(posedge clk) disable iff (rst)
		out_valid && res_significand != '0 |-> res_significand[`FAS_MAN_W])
		else $error("fas_normalize: result not normalized, %h", res_significand);

endmodule

//--- fas_operand_order.sv
`include "fas_settings.svh"

// Stage 1, sort by magnitude and unpack
module fas_operand_order (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  do_fadd,
	input  logic                  do_fsub,
	input  logic [`FAS_FLT_W-1:0] a,
	input  logic [`FAS_FLT_W-1:0] b,
	fas_stage_if.source           ord
);

	localparam int MAG_W = `FAS_FLT_W - 1;

	logic                  start;
	logic                  a_first;
	logic                  b_sign;
	fas_pkg::fas_operand_t a_op;
	fas_pkg::fas_operand_t b_op;

	// Zero magnitude gives an all-zero operand, sign included
	function automatic fas_pkg::fas_operand_t unpack_op(
		input logic             sign,
		input logic [MAG_W-1:0] mag
	);
		fas_pkg::fas_operand_t op;
		op = '0;
		if (mag != '0) begin
			op.sign        = sign;
			op.exponent    = `FAS_EXP_W'(mag[MAG_W-1:`FAS_MAN_W]);
			op.significand = `FAS_SIG_W'({1'b1, mag[`FAS_MAN_W-1:0]});
		end
		return op;
	endfunction

	//////////////////////////////////////////////////
	// Compare and unpack
	//////////////////////////////////////////////////

	assign start = do_fadd | do_fsub;

	// Tie keeps a in front
	assign a_first = a[MAG_W-1:0] >= b[MAG_W-1:0];

	// Subtract is an add with b negated, wherever b ends up
	assign b_sign = b[MAG_W] ^ do_fsub;

	assign a_op = unpack_op(a[MAG_W], a[MAG_W-1:0]);
	assign b_op = unpack_op(b_sign, b[MAG_W-1:0]);

	always_ff @(posedge clk) begin
		if (rst) begin
			ord.valid   <= 1'b0;
			ord.payload <= '0;
		end else begin
			ord.valid <= start;
			// Hold the pair between strobes
			if (start) begin
				ord.payload.larger  <= a_first ? a_op : b_op;
				ord.payload.smaller <= a_first ? b_op : a_op;
			end
		end
	end

	// Only one operation per cycle
	a_one_op: assert property (@(posedge clk) disable iff (rst) !(do_fadd && do_fsub))
		else $error("fas_operand_order: do_fadd and do_fsub both high");

endmodule

//--- fas_pkg.sv
`include "fas_settings.svh"

package fas_pkg;

	//////////////////////////////////////////////////
	// Operand formats
	//////////////////////////////////////////////////

	// Unpacked float, 42 bits
	// Hidden one at bit FAS_MAN_W of the significand
	typedef struct packed {
		logic                  sign;
		logic [`FAS_EXP_W-1:0] exponent;
		logic [`FAS_SIG_W-1:0] significand;
	} fas_operand_t;

	// Stage 1 result, operands sorted by magnitude
	typedef struct packed {
		fas_operand_t larger;
		fas_operand_t smaller;
	} fas_pair_t;

	//////////////////////////////////////////////////
	// Stage payloads
	//////////////////////////////////////////////////

	// Both significands on a common exponent
	// Base exponent already accounts for the guard bits
	typedef struct packed {
		logic                  lg_sign;
		logic [`FAS_SIG_W-1:0] lg_sig;
		logic                  sm_sign;
		logic [`FAS_SIG_W-1:0] sm_sig;
		logic [`FAS_EXP_W-1:0] base_exp;
	} fas_aligned_t;

	// Rounded, not yet normalized
	typedef struct packed {
		fas_operand_t rnd;
	} fas_sum_t;

endpackage

//--- fas_settings.svh
`ifndef FAS_SETTINGS_SVH
`define FAS_SETTINGS_SVH

//////////////////////////////////////////////////
// Operand and datapath widths
//////////////////////////////////////////////////

// IEEE single precision word
`define FAS_FLT_W        32
// Stored mantissa bits, hidden one lands just above
`define FAS_MAN_W        23
// Internal exponent, one bit wider than IEEE
`define FAS_EXP_W        9
// Internal significand register
`define FAS_SIG_W        32
// Shift amount covers 0 to 32
`define FAS_SHIFT_W      6

//////////////////////////////////////////////////
// Pipeline constants
//////////////////////////////////////////////////

// Guard bits in front of the larger operand
`define FAS_GUARD_SHIFT  7
// Round on this bit, add one step at the same weight
`define FAS_ROUND_BIT    6
// Anything below this is treated as zero
`define FAS_FLUSH_LIMIT  15
// Leading-one search stops here
`define FAS_NORM_MIN_BIT 8

`endif

//--- fas_shift32.sv
`include "fas_settings.svh"

// Barrel shift built on two 16x16 multipliers
// Left or right by 0 to 32, combinational
module fas_shift32 (
	input  logic [`FAS_SHIFT_W-1:0] shift_n,
	input  logic                    shift_left,
	input  logic [`FAS_SIG_W-1:0]   v,
	output logic [`FAS_SIG_W-1:0]   q
);

	localparam int HALF  = `FAS_SIG_W / 2;
	localparam int DEC_W = $clog2(HALF);
	localparam logic [`FAS_SHIFT_W-1:0] SH_FULL = `FAS_SIG_W;

	logic [DEC_W-1:0]      dec_n;
	logic [HALF-1:0]       mul_b;
	logic [`FAS_SIG_W-1:0] hi;
	logic [`FAS_SIG_W-1:0] lo;
	logic [`FAS_SIG_W-1:0] shl_in;
	logic [`FAS_SIG_W-1:0] shr_in;
	logic [`FAS_SIG_W-1:0] shl_x;
	logic [`FAS_SIG_W-1:0] shr_x;

	//////////////////////////////////////////////////
	// Multiplier operand
	//////////////////////////////////////////////////

	// Right shift by n is a left shift by 16-n, read from the upper half
	assign dec_n = shift_left ? shift_n[DEC_W-1:0] : -shift_n[DEC_W-1:0];

	// One-hot power of two
	always_comb begin
		mul_b        = '0;
		mul_b[dec_n] = 1'b1;
	end

	// Full 32-bit products of each half
	assign hi = {{HALF{1'b0}}, v[`FAS_SIG_W-1:HALF]} * {{HALF{1'b0}}, mul_b};
	assign lo = {{HALF{1'b0}}, v[HALF-1:0]} * {{HALF{1'b0}}, mul_b};

	//////////////////////////////////////////////////
	// Half recombination
	//////////////////////////////////////////////////

	// n below 16, both halves contribute
	assign shl_in = {hi[HALF-1:0], {HALF{1'b0}}} | lo;
	assign shr_in = hi | {{HALF{1'b0}}, lo[`FAS_SIG_W-1:HALF]}; 

	// n of 16 and up, only one half survives
	assign shl_x = {lo[HALF-1:0], {HALF{1'b0}}};
	assign shr_x = {{HALF{1'b0}}, hi[`FAS_SIG_W-1:HALF]};

	always_comb begin
		if (shift_n == SH_FULL) begin
			q = '0;
		end else if (shift_n == '0) begin
			q = v;
		end else if (!shift_n[DEC_W]) begin
			q = shift_left ? shl_in : shr_in;
		end else if (shift_left) begin
			q = shl_x;
		end else if (shift_n[DEC_W-1:0] == '0) begin
			// Right by 16, multiplier runs at unity so hi is already the answer
			q = hi;
		end else begin
			q = shr_x;
		end
	end

	// Callers must keep the amount in range
	always_comb begin
		a_shift_range: assert final (shift_n <= SH_FULL)
			else $error("fas_shift32: shift amount %0d out of range", shift_n);
	end

endmodule

//--- fas_stage_if.sv
// One pipeline hop between two stages
// Valid-only, every item is taken on the cycle it shows up
interface fas_stage_if #(
	parameter type payload_t = logic
);

	// Marks one item for one cycle
	logic     valid;
	// Stage specific data, held between items
	payload_t payload;

	// Upstream stage
	modport source (
		output valid,
		output payload
	);

	// Downstream stage
	modport sink (
		input valid,
		input payload
	);

endinterface

//--- fp_addsub_top.f
+incdir+.
fas_pkg.sv
fas_stage_if.sv
fas_shift32.sv
fas_operand_order.sv
fas_align.sv
fas_add_round.sv
fas_normalize.sv
fp_addsub_top.sv
tb_fp_addsub.sv

//--- fp_addsub_top.sv
`include "fas_settings.svh"

// Five-stage float add/sub, result left unpacked
module fp_addsub_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  do_fadd,
	input  logic                  do_fsub,
	input  logic [`FAS_FLT_W-1:0] a,
	input  logic [`FAS_FLT_W-1:0] b,
	output logic                  out_valid,
	output logic                  res_sign,
	output logic [`FAS_EXP_W-1:0] res_exponent,
	output logic [`FAS_SIG_W-1:0] res_significand
);

	//////////////////////////////////////////////////
	// Stage links
	//////////////////////////////////////////////////

	fas_stage_if #(.payload_t(fas_pkg::fas_pair_t))    ord_if ();
	fas_stage_if #(.payload_t(fas_pkg::fas_aligned_t)) aln_if ();
	fas_stage_if #(.payload_t(fas_pkg::fas_sum_t))     sum_if ();

	// Stage 1
	fas_operand_order u_order (
		.clk     (clk),
		.rst     (rst),
		.do_fadd (do_fadd),
		.do_fsub (do_fsub),
		.a       (a),
		.b       (b),
		.ord     (ord_if)
	);

	// Stage 2
	fas_align u_align (
		.clk (clk),
		.rst (rst),
		.ord (ord_if),
		.aln (aln_if)
	);

	// Stages 3 and 4
	fas_add_round u_add_round (
		.clk (clk),
		.rst (rst),
		.aln (aln_if),
		.sum (sum_if)
	);

	// Stage 5
	fas_normalize u_normalize (
		.clk             (clk),
		.rst             (rst),
		.sum             (sum_if),
		.out_valid       (out_valid),
		.res_sign        (res_sign),
		.res_exponent    (res_exponent),
		.res_significand (res_significand)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FP add/sub testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_fp_addsub \
	-f fp_addsub_top.f \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi

//--- tb_fp_addsub.sv
`include "fas_settings.svh"

module tb_fp_addsub;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LATENCY        = 5;
	localparam int N_RANDOM       = 150;
	localparam int N_BURST        = 200;
	// Directed sends plus idle gaps between groups
	localparam int N_DIRECTED_CYC = 80;
	localparam int STIM_CYCLES    = 5 + N_DIRECTED_CYC + N_RANDOM + N_BURST + 20;
	localparam int TIMEOUT        = STIM_CYCLES + 50;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  do_fadd;
	logic                  do_fsub;
	logic [`FAS_FLT_W-1:0] a;
	logic [`FAS_FLT_W-1:0] b;
	logic                  out_valid;
	logic                  res_sign;
	logic [`FAS_EXP_W-1:0] res_exponent;
	logic [`FAS_SIG_W-1:0] res_significand;

	// Scoreboard with one entry per accepted pair
	fas_pkg::fas_operand_t exp_q[$];
	string                 name_q[$];
	int                    cyc_q[$];

	int          cycle      = 0;
	int          errors     = 0;
	int          sent_count = 0;
	int          recv_count = 0;
	string       cur_name   = "idle";
	logic [31:0] rng        = 32'd57315;

	fp_addsub_top dut (
		.clk             (clk),
		.rst             (rst),
		.do_fadd         (do_fadd),
		.do_fsub         (do_fsub),
		.a               (a),
		.b               (b),
		.out_valid       (out_valid),
		.res_sign        (res_sign),
		.res_exponent    (res_exponent),
		.res_significand (res_significand)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic fas_pkg::fas_operand_t unpack_ref(input logic s, input logic [30:0] mag);
		fas_pkg::fas_operand_t op;
		op = '0;
		if (mag != 31'd0) begin
			op.sign        = s;
			op.exponent    = {1'b0, mag[30:23]};
			op.significand = {8'd0, 1'b1, mag[22:0]};
		end
		return op;
	endfunction

	function automatic fas_pkg::fas_operand_t fas_model(
		input logic [31:0] op_a,
		input logic [31:0] op_b,
		input logic        sub
	);
		fas_pkg::fas_operand_t ua;
		fas_pkg::fas_operand_t ub;
		fas_pkg::fas_operand_t lg;
		fas_pkg::fas_operand_t sm;
		fas_pkg::fas_operand_t res;
		logic [8:0]            diff;
		logic [8:0]            base;
		logic [31:0]           lg_sig;
		logic [31:0]           sm_sig;
		logic [31:0]           sum;
		int                    p;
		int                    i;
		ua = unpack_ref(op_a[31], op_a[30:0]);
		ub = unpack_ref(op_b[31] ^ sub, op_b[30:0]);
		// Larger magnitude first and a wins a tie
		if (op_a[30:0] >= op_b[30:0]) begin
			lg = ua;
			sm = ub;
		end else begin
			lg = ub;
			sm = ua;
		end
		diff   = lg.exponent - sm.exponent;
		base   = lg.exponent - 9'(`FAS_GUARD_SHIFT);
		lg_sig = lg.significand << `FAS_GUARD_SHIFT;
		// Ideal alignment shift
		if (diff < 9'(`FAS_GUARD_SHIFT))
			sm_sig = sm.significand << (`FAS_GUARD_SHIFT - int'(diff));
		else if (diff <= 9'(`FAS_GUARD_SHIFT + 31))
			sm_sig = sm.significand >> (int'(diff) - `FAS_GUARD_SHIFT);
		else
			sm_sig = 32'd0;
		if (sm_sig == 32'd0)
			sum = lg_sig;
		else if (lg.sign == sm.sign)
			sum = lg_sig + sm_sig;
		else
			sum = lg_sig - sm_sig;
		// Round half up at the guard position
		if (sum[`FAS_ROUND_BIT])
			sum = sum + (32'd1 << `FAS_ROUND_BIT);
		res = '0;
		if (sum < 32'(`FAS_FLUSH_LIMIT))
			return res;
		p = -1;
		for (i = 31; i >= `FAS_NORM_MIN_BIT; i--) begin
			if (sum[i] && p < 0)
				p = i;
		end
		res.sign = lg.sign;
		if (p < 0) begin
			res.significand = sum << 16;
			res.exponent    = 9'd0;
		end else if (p >= `FAS_MAN_W) begin
			res.significand = sum >> (p - `FAS_MAN_W);
			res.exponent    = base + 9'(p - `FAS_MAN_W);
		end else begin
			res.significand = sum << (`FAS_MAN_W - p);
			res.exponent    = base - 9'(`FAS_MAN_W - p);
		end
		return res;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Random float with exponent 20 to 230
	task automatic rand_float(output logic [31:0] f);
		rng       = lcg_next(rng);
		f[31]     = rng[31];
		f[22:0]   = rng[30:8];
		rng       = lcg_next(rng);
		f[30:23]  = 8'(32'd20 + {16'd0, rng[31:16]} % 32'd211);
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_operand(input string name, input fas_pkg::fas_operand_t expv,
		input fas_pkg::fas_operand_t actv);
		if (actv !== expv) begin
			errors++;
			$display("[ERROR] %s: expected s=%0b e=%h m=%h, actual s=%0b e=%h m=%h", name,
				expv.sign, expv.exponent, expv.significand,
				actv.sign, actv.exponent, actv.significand);
		end
	endtask

	task automatic check_valid_count(input string name, input int expv, input int actv);
		if (actv != expv) begin
			errors++;
			$display("[ERROR] %s: expected %0d results, actual %0d", name, expv, actv);
		end
	endtask

	task automatic check_latency(input string name, input int expv, input int actv);
		if (actv != expv) begin
			errors++;
			$display("[ERROR] %s latency: expected %0d, actual %0d", name, expv, actv);
		end
	endtask

	//////////////////////////////////////////////////
	// Cycle count, monitor and scoreboard
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT) begin
			$display("Timeout, run did not finish within %0d cycles", TIMEOUT);
			$display("errors: %0d, sent: %0d, received: %0d", errors, sent_count, recv_count);
			$display("test failed");
			$finish;
		end
	end

	// Inputs are stable by the falling edge
	always @(negedge clk) begin
		if (!rst && (do_fadd || do_fsub)) begin
			exp_q.push_back(fas_model(a, b, do_fsub));
			name_q.push_back(cur_name);
			cyc_q.push_back(cycle);
		end
	end

	always @(negedge clk) begin
		fas_pkg::fas_operand_t actv;
		string                 nm;
		int                    issued;
		actv = {res_sign, res_exponent, res_significand};
		if (rst && out_valid !== 1'b0) begin
			errors++;
			$display("out_valid was not low while reset was asserted");
		end else if (out_valid) begin
			recv_count++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("out_valid went high with no operation in flight");
			end else begin
				nm     = name_q.pop_front();
				issued = cyc_q.pop_front();
				check_operand(nm, exp_q.pop_front(), actv);
				check_latency(nm, LATENCY, cycle - issued);
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Holds the pair for one cycle from 1 ns after an edge
	task automatic send(input string name, input logic [31:0] op_a, input logic [31:0] op_b,
		input logic sub);
		cur_name = name;
		a        = op_a;
		b        = op_b;
		do_fadd  = !sub;
		do_fsub  = sub;
		sent_count++;
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int n);
		do_fadd = 1'b0;
		do_fsub = 1'b0;
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		idle(1);
		// Every pending result is due within the pipeline latency
		while (exp_q.size() != 0 && waited < LATENCY + 2) begin
			@(posedge clk);
			waited++;
		end
		// Quiet tail catches duplicates
		repeat (10) @(posedge clk);
		#1;
	endtask

	initial begin
		int          diffs[7];
		int          i;
		int          burst_base;
		logic [31:0] ra;
		logic [31:0] rb;
		logic [31:0] sb;
		diffs   = '{0, 6, 7, 8, 38, 39, 60};
		rst     = 1'b1;
		do_fadd = 1'b0;
		do_fsub = 1'b0;
		a       = '0;
		b       = '0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		// Strobe on the first cycle out of reset
		send("first_after_reset", 32'h3F800000, 32'h40000000, 1'b0);
		idle(6);

		// Adds
		send("add_one_one", 32'h3F800000, 32'h3F800000, 1'b0);
		send("add_mixed_sign", 32'h3FC00000, 32'hBF000000, 1'b0);
		send("add_equal_exp", 32'h40400000, 32'h40200000, 1'b0);
		send("add_neg_equal_exp", 32'hC0200000, 32'hC0400000, 1'b0);
		send("add_zero_both", 32'h00000000, 32'h00000000, 1'b0);
		idle(1);

		// Subtracts and ordering
		send("sub_a_lt_b", 32'h3F800000, 32'h40000000, 1'b1);
		send("sub_a_gt_b", 32'h40000000, 32'h3F800000, 1'b1);
		send("sub_equal", 32'h3FC00000, 32'h3FC00000, 1'b1);
		send("sub_zero_a", 32'h00000000, 32'h40400000, 1'b1);
		send("sub_zero_b", 32'h40400000, 32'h00000000, 1'b1);
		send("sub_negzero_b", 32'hC0200000, 32'h80000000, 1'b1);
		idle(1);

		// Alignment extremes with b below a by d
		for (i = 0; i < 7; i++) begin
			sb = {1'b0, 8'(127 - diffs[i]), 23'h2AAAAA};
			send($sformatf("align_d%0d_add", diffs[i]), 32'h3F800000, sb, 1'b0);
			send($sformatf("align_d%0d_sub", diffs[i]), 32'h3F800000, sb, 1'b1);
		end
		idle(1);

		// Rounding carries out of the top and deep cancellation
		send("round_carry", 32'h3FFFFFFF, 32'h33800000, 1'b0);
		send("round_carry_neg", 32'hBFFFFFFF, 32'hB3800000, 1'b0);
		send("round_up", 32'h3F800000, 32'h33C00000, 1'b0);
		send("cancel_12", 32'h3F800010, 32'h3F800000, 1'b1);
		send("cancel_11", 32'h3F800020, 32'h3F800000, 1'b1);
		send("cancel_neg", 32'h3F800000, 32'h3F800030, 1'b1);
		send("cancel_cross_exp", 32'h40000000, 32'h3FFFFFF0, 1'b1);
		idle(1);

		// Random adds
		for (i = 0; i < N_RANDOM; i++) begin
			rand_float(ra);
			rand_float(rb);
			send("random_add", ra, rb, 1'b0);
		end
		drain();

		// Back-to-back mixed ops
		burst_base = recv_count;
		for (i = 0; i < N_BURST; i++) begin
			rand_float(ra);
			rand_float(rb);
			rng = lcg_next(rng);
			send("burst", ra, rb, rng[20]);
		end
		drain();
		check_valid_count("burst", N_BURST, recv_count - burst_base);

		check_valid_count("total", sent_count, recv_count);
		$display("errors: %0d, sent: %0d, received: %0d", errors, sent_count, recv_count);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
